/* sim.f */
common/puzzle_pkg.sv
board/level_rom.sv
board/board_store.sv
rtl/slide_engine.sv
rtl/game_sequencer.sv
rtl/puzzle_top.sv
testbench/puzzle_properties.sv
testbench/puzzle_tb.sv

/* testbench/puzzle_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module puzzle_tb;
        import puzzle_pkg::*;

        // all three routes take a few hundred cycles, so this leaves a wide margin
        localparam int MAX_CYCLES = 2000;

        localparam logic [3:0] RIGHT = 4'b1000;
        localparam logic [3:0] LEFT  = 4'b0100;
        localparam logic [3:0] UP    = 4'b0010;
        localparam logic [3:0] DOWN  = 4'b0001;

        logic        logicClock;
        logic        reset;
        logic        right;
        logic        left;
        logic        up;
        logic        down;
        col_t        peek_col;
        row_t        peek_row;
        col_t        cell_col;
        row_t        cell_row;
        gems_t       gems_left;
        level_t      level;
        logic        moving;
        logic        won;
        logic        lost;
        cell_t       peek_cell;
        level_t      route_level;
        logic [15:0] lfsr_state = 16'd64988;
        int          value_errors = 0;
        int          cycle_count = 0;

        puzzle_top #(
                .NUM_LEVELS (2)
        ) UUT (
                .logicClock (logicClock),
                .reset      (reset),
                .right      (right),
                .left       (left),
                .up         (up),
                .down       (down),
                .peek_col   (peek_col),
                .peek_row   (peek_row),
                .cell_col   (cell_col),
                .cell_row   (cell_row),
                .gems_left  (gems_left),
                .level      (level),
                .moving     (moving),
                .won        (won),
                .lost       (lost),
                .peek_cell  (peek_cell)
        );

        bind puzzle_top puzzle_properties u_props (
                .logicClock (logicClock),
                .reset      (reset),
                .moving     (moving),
                .load       (load),
                .won        (won),
                .lost       (lost),
                .cell_col   (cell_col),
                .cell_row   (cell_row),
                .gems_left  (gems_left),
                .level      (level),
                .here_cell  (here_cell)
        );

        initial begin
                logicClock = 1'b0;
                forever begin
                        #50 logicClock = ~logicClock;
                end
        end

        always @(posedge logicClock) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= MAX_CYCLES) begin
                        $display("run timed out after %0d cycles", cycle_count);
                        $display("Test failed");
                        $finish;
                end
        end

        ////////////////////////////////////////////////////////////
        // stimulus helpers
        ////////////////////////////////////////////////////////////

        // taps 16, 14, 13, 11
        function automatic logic [15:0] lfsr_step(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        // both level layouts, grouped by cell code
        function automatic cell_t layout_cell(input level_t lv, input col_t c, input row_t r);
                case ({lv, c, r})
                        {2'd0, 3'd0, 4'd4}, {2'd1, 3'd0, 4'd2}, {2'd1, 3'd4, 4'd4},
                        {2'd1, 3'd5, 4'd4}, {2'd1, 3'd1, 4'd8}: return CELL_WALL;
                        {2'd0, 3'd1, 4'd4}, {2'd0, 3'd1, 4'd7}, {2'd1, 3'd1, 4'd4},
                        {2'd1, 3'd0, 4'd6}, {2'd1, 3'd5, 4'd7}: return CELL_GEM;
                        {2'd0, 3'd4, 4'd5}, {2'd1, 3'd0, 4'd4},
                        {2'd1, 3'd6, 4'd6}: return CELL_BOMB;
                        {2'd0, 3'd4, 4'd4}, {2'd1, 3'd1, 4'd0}, {2'd1, 3'd2, 4'd4},
                        {2'd1, 3'd4, 4'd8}, {2'd1, 3'd6, 4'd8}: return CELL_STOP;
                        default: return CELL_EMPTY;
                endcase
        endfunction

        task automatic take_bits(input int n, output logic [7:0] bits);
                bits = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr_state = lfsr_step(lfsr_state);
                        bits = {bits[6:0], lfsr_state[0]};
                end
        endtask

        task automatic random_peek();
                logic [7:0] bits;
                cell_t      expected;
                take_bits(3, bits);
                peek_col = col_t'(bits[2:0]);
                take_bits(4, bits);
                peek_row = row_t'(bits[3:0] % 10);
                expected = layout_cell(route_level, peek_col, peek_row);
                @(negedge logicClock);
                // a gem may already be collected
                if (peek_cell !== expected
                                && !(expected == CELL_GEM && peek_cell === CELL_EMPTY)) begin
                        value_errors++;
                        $display("ERROR %0t: cell (%0d,%0d) reads %0d, expected %0d",
                                $time, peek_col, peek_row, peek_cell, expected);
                end
        endtask

        // inputs change shortly after the rising edge
        task automatic next_cycle();
                @(posedge logicClock);
                #5;
        endtask

        task automatic set_buttons(input logic [3:0] btn);
                {right, left, up, down} = btn;
        endtask

        task automatic apply_reset();
                reset = 1'b1;
                repeat (4) next_cycle();
                reset = 1'b0;
                // level 0 lands on the first edge out of reset
                next_cycle();
        endtask

        task automatic press(input logic [3:0] btn);
                set_buttons(btn);
                next_cycle();
                set_buttons(4'b0000);
                next_cycle();
                while (moving) begin
                        random_peek();
                        next_cycle();
                end
        endtask

        task automatic expect_state(input col_t c, input row_t r, input gems_t g,
                        input level_t lv, input logic w, input logic lo);
                @(negedge logicClock);
                if (cell_col !== c || cell_row !== r || gems_left !== g || level !== lv
                                || moving !== 1'b0 || won !== w || lost !== lo) begin
                        value_errors++;
                        $display("ERROR %0t: want (%0d,%0d) gems %0d level %0d won %0b lost %0b",
                                $time, c, r, g, lv, w, lo);
                        $display("ERROR %0t: got (%0d,%0d) gems %0d level %0d won %0b lost %0b",
                                $time, cell_col, cell_row, gems_left, level, won, lost);
                        if (moving !== 1'b0) begin
                                $display("ERROR %0t: token still moving", $time);
                        end
                end
                next_cycle();
        endtask

        task automatic expect_peek(input col_t c, input row_t r, input cell_t exp);
                peek_col = c;
                peek_row = r;
                @(negedge logicClock);
                if (peek_cell !== exp) begin
                        value_errors++;
                        $display("ERROR %0t: cell (%0d,%0d) reads %0d, expected %0d",
                                $time, c, r, peek_cell, exp);
                end
                next_cycle();
        endtask

        task automatic slide_to(input logic [3:0] btn, input col_t c, input row_t r,
                        input gems_t g, input level_t lv);
                press(btn);
                expect_state(c, r, g, lv, 1'b0, 1'b0);
        endtask

        ////////////////////////////////////////////////////////////
        // test sequence
        ////////////////////////////////////////////////////////////

        initial begin
                reset = 1'b1;
                set_buttons(4'b0000);
                peek_col = '0;
                peek_row = '0;
                route_level = 2'd0;
                apply_reset();
                expect_state(3'd4, 4'd2, 5'd2, 2'd0, 1'b0, 1'b0);
                expect_peek(3'd1, 4'd4, CELL_GEM);

                // level 0
                slide_to(DOWN, 3'd4, 4'd4, 5'd2, 2'd0);
                slide_to(LEFT, 3'd1, 4'd4, 5'd1, 2'd0);
                expect_peek(3'd1, 4'd4, CELL_EMPTY);
                slide_to(DOWN, 3'd1, 4'd9, 5'd0, 2'd0);
                while (gems_left == '0) begin
                        next_cycle();
                end
                expect_state(3'd4, 4'd8, 5'd3, 2'd1, 1'b0, 1'b0);

                // level 1
                route_level = 2'd1;
                slide_to(UP, 3'd4, 4'd5, 5'd3, 2'd1);
                slide_to(LEFT, 3'd0, 4'd5, 5'd3, 2'd1);
                slide_to(DOWN, 3'd0, 4'd9, 5'd2, 2'd1);
                expect_peek(3'd0, 4'd6, CELL_EMPTY);
                slide_to(RIGHT, 3'd7, 4'd9, 5'd2, 2'd1);
                slide_to(UP | LEFT, 3'd6, 4'd8, 5'd2, 2'd1);
                slide_to(DOWN | LEFT, 3'd5, 4'd9, 5'd2, 2'd1);
                slide_to(UP, 3'd5, 4'd5, 5'd1, 2'd1);
                slide_to(RIGHT, 3'd7, 4'd5, 5'd1, 2'd1);
                slide_to(UP, 3'd7, 4'd0, 5'd1, 2'd1);
                slide_to(LEFT, 3'd1, 4'd0, 5'd1, 2'd1);
                slide_to(DOWN, 3'd1, 4'd7, 5'd0, 2'd1);
                while (!won) begin
                        next_cycle();
                end
                expect_state(3'd1, 4'd7, 5'd0, 2'd1, 1'b1, 1'b0);
                press(RIGHT);
                press(UP);
                expect_state(3'd1, 4'd7, 5'd0, 2'd1, 1'b1, 1'b0);

                // bomb run from a fresh start
                route_level = 2'd0;
                apply_reset();
                slide_to(DOWN, 3'd4, 4'd4, 5'd2, 2'd0);
                press(DOWN);
                while (!lost) begin
                        next_cycle();
                end
                expect_state(3'd4, 4'd5, 5'd2, 2'd0, 1'b0, 1'b1);
                press(LEFT);
                press(UP);
                expect_state(3'd4, 4'd5, 5'd2, 2'd0, 1'b0, 1'b1);

                $display("assertion failures: %0d, value errors: %0d",
                        UUT.u_props.fail_count, value_errors);
                if (UUT.u_props.fail_count == 0 && value_errors == 0) begin
                        $display("Test completed successfully");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* testbench/puzzle_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module puzzle_properties (
        input logic                logicClock,
        input logic                reset,
        input logic                moving,
        input logic                load,
        input logic                won,
        input logic                lost,
        input puzzle_pkg::col_t    cell_col,
        input puzzle_pkg::row_t    cell_row,
        input puzzle_pkg::gems_t   gems_left,
        input puzzle_pkg::level_t  level,
        input puzzle_pkg::cell_t   here_cell
);
        import puzzle_pkg::*;

        int fail_count = 0;

        task automatic note_failure(input string what);
                fail_count++;
                $error("%s", what);
        endtask

        // at most one cell on each axis, and never zero
        function automatic logic one_step(input col_t dc, input row_t dr);
                return (dc == 3'd0 || dc == 3'd1 || dc == 3'd7)
                        && (dr == 4'd0 || dr == 4'd1 || dr == 4'd15)
                        && !(dc == 3'd0 && dr == 4'd0);
        endfunction

        ////////////////////////////////////////////////////////////
        // token movement
        ////////////////////////////////////////////////////////////

        a_idle_still: assert property (@(posedge logicClock) disable iff (reset)
                !moving && !$past(load) |-> $stable(cell_col) && $stable(cell_row))
                else note_failure("token moved while the engine was idle");

        a_one_step: assert property (@(posedge logicClock) disable iff (reset)
                moving |-> one_step(cell_col - $past(cell_col), cell_row - $past(cell_row)))
                else note_failure("slide step was not a single cell");

        // latched direction holds for the whole slide
        a_same_dir: assert property (@(posedge logicClock) disable iff (reset)
                moving && $past(moving)
                |-> col_t'(cell_col - $past(cell_col))
                        == col_t'($past(cell_col) - $past(cell_col, 2))
                && row_t'(cell_row - $past(cell_row))
                        == row_t'($past(cell_row) - $past(cell_row, 2)))
                else note_failure("slide changed direction");

        a_no_wall: assert property (@(posedge logicClock) disable iff (reset)
                here_cell != CELL_WALL)
                else note_failure("token stands on a wall");

        ////////////////////////////////////////////////////////////
        // gems, bombs and end of game
        ////////////////////////////////////////////////////////////

        a_gem_drop: assert property (@(posedge logicClock) disable iff (reset)
                gems_left != $past(gems_left) && !$past(load)
                |-> gems_left == $past(gems_left) - 5'd1 && $past(here_cell) == CELL_GEM)
                else note_failure("gem count changed without a gem under the token");

        a_gem_taken: assert property (@(posedge logicClock) disable iff (reset)
                here_cell == CELL_GEM |=> gems_left == $past(gems_left) - 5'd1)
                else note_failure("gem under the token was not counted");

        a_bomb_loss: assert property (@(posedge logicClock) disable iff (reset)
                here_cell == CELL_BOMB && !won && !lost |=> lost)
                else note_failure("bomb entered but the game was not lost");

        a_frozen: assert property (@(posedge logicClock) disable iff (reset)
                won || lost |=> $stable(cell_col) && $stable(cell_row)
                && $stable(gems_left) && $stable(level) && !moving)
                else note_failure("state changed after the game ended");

endmodule

`default_nettype wire

/* rtl/puzzle_top.sv */
`timescale 1ns/1ps
`default_nettype none

module puzzle_top #(
        parameter int NUM_LEVELS = 2
) (
        input  logic                logicClock,
        input  logic                reset,
        input  logic                right,
        input  logic                left,
        input  logic                up,
        input  logic                down,
        input  puzzle_pkg::col_t    peek_col,
        input  puzzle_pkg::row_t    peek_row,
        output puzzle_pkg::col_t    cell_col,
        output puzzle_pkg::row_t    cell_row,
        output puzzle_pkg::gems_t   gems_left,
        output puzzle_pkg::level_t  level,
        output logic                moving,
        output logic                won,
        output logic                lost,
        output puzzle_pkg::cell_t   peek_cell
);
        import puzzle_pkg::*;

        col_t  [NUM_CELLS-1:0] load_col;
        row_t  [NUM_CELLS-1:0] load_row;
        cell_t [NUM_CELLS-1:0] rom_cell;
        col_t   start_col;
        row_t   start_row;
        gems_t  gem_total;
        cell_t  here_cell;
        cell_t  ahead_cell;
        dir_t   ahead_dir;
        logic   load;
        logic   collect;
        logic   freeze;

        ////////////////////////////////////////////////////////////
        // level tables
        ////////////////////////////////////////////////////////////

        // one lookup per cell so a whole level lands in a single cycle
        for (genvar i = 0; i < NUM_CELLS; i++) begin : g_rom
                if (i == 0) begin : g_first
                        level_rom u_rom (
                                .level_sel (level),
                                .rom_col   (load_col[i]),
                                .rom_row   (load_row[i]),
                                .rom_cell  (rom_cell[i]),
                                .start_col (start_col),
                                .start_row (start_row),
                                .gem_total (gem_total)
                        );
                end else begin : g_rest
                        // start cell and gem total are taken from the first lookup
                        level_rom u_rom (
                                .level_sel (level),
                                .rom_col   (load_col[i]),
                                .rom_row   (load_row[i]),
                                .rom_cell  (rom_cell[i]),
                                .start_col (),
                                .start_row (),
                                .gem_total ()
                        );
                end
        end

        ////////////////////////////////////////////////////////////
        // board, token and game state
        ////////////////////////////////////////////////////////////

        board_store u_board (
                .logicClock (logicClock),
                .reset      (reset),
                .load       (load),
                .load_col   (load_col),
                .load_row   (load_row),
                .rom_cell   (rom_cell),
                .collect    (collect),
                .cell_col   (cell_col),
                .cell_row   (cell_row),
                .here_cell  (here_cell),
                .ahead_dir  (ahead_dir),
                .ahead_cell (ahead_cell),
                .peek_col   (peek_col),
                .peek_row   (peek_row),
                .peek_cell  (peek_cell)
        );

        slide_engine u_slide (
                .logicClock (logicClock),
                .reset      (reset),
                .right      (right),
                .left       (left),
                .up         (up),
                .down       (down),
                .freeze     (freeze),
                .load       (load),
                .start_col  (start_col),
                .start_row  (start_row),
                .here_cell  (here_cell),
                .ahead_cell (ahead_cell),
                .ahead_dir  (ahead_dir),
                .cell_col   (cell_col),
                .cell_row   (cell_row),
                .moving     (moving)
        );

        game_sequencer #(
                .NUM_LEVELS (NUM_LEVELS)
        ) u_seq (
                .logicClock (logicClock),
                .reset      (reset),
                .here_cell  (here_cell),
                .moving     (moving),
                .gem_total  (gem_total),
                .collect    (collect),
                .load       (load),
                .level_sel  (level),
                .freeze     (freeze),
                .gems_left  (gems_left),
                .won        (won),
                .lost       (lost)
        );

endmodule

`default_nettype wire

/* rtl/game_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module game_sequencer #(
        parameter int NUM_LEVELS = 2
) (
        input  logic                logicClock,
        input  logic                reset,
        input  puzzle_pkg::cell_t   here_cell,
        input  logic                moving,
        input  puzzle_pkg::gems_t   gem_total,
        output logic                collect,
        output logic                load,
        output puzzle_pkg::level_t  level_sel,
        output logic                freeze,
        output puzzle_pkg::gems_t   gems_left,
        output logic                won,
        output logic                lost
);
        import puzzle_pkg::*;

        logic last_level;

        assign last_level = level_sel == level_t'(NUM_LEVELS - 1);
        assign freeze     = won | lost;
        assign collect    = here_cell == CELL_GEM;

        always_ff @(posedge logicClock or posedge reset) begin
                if (reset) begin
                        level_sel <= '0;
                        gems_left <= '0;
                        // level 0 is loaded on the first edge out of reset
                        load      <= 1'b1;
                        won       <= 1'b0;
                        lost      <= 1'b0;
                end else begin
                        load <= 1'b0;
                        if (load) begin
                                gems_left <= gem_total;
                        end else if (collect) begin
                                gems_left <= gems_left - 1'b1;
                        end
                        // loss wins over level advance
                        if (!freeze && !load) begin
                                if (here_cell == CELL_BOMB) begin
                                        lost <= 1'b1;
                                end else if (gems_left == '0 && !moving) begin
                                        if (last_level) begin
                                                won <= 1'b1;
                                        end else begin
                                                load      <= 1'b1;
                                                level_sel <= level_sel + 1'b1;
                                        end
                                end
                        end
                end
        end

endmodule

`default_nettype wire

/* rtl/slide_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module slide_engine (
        input  logic               logicClock,
        input  logic               reset,
        input  logic               right,
        input  logic               left,
        input  logic               up,
        input  logic               down,
        input  logic               freeze,
        input  logic               load,
        input  puzzle_pkg::col_t   start_col,
        input  puzzle_pkg::row_t   start_row,
        input  puzzle_pkg::cell_t  here_cell,
        input  puzzle_pkg::cell_t  ahead_cell,
        output puzzle_pkg::dir_t   ahead_dir,
        output puzzle_pkg::col_t   cell_col,
        output puzzle_pkg::row_t   cell_row,
        output logic               moving
);
        import puzzle_pkg::*;

        dir_t buttons_q;
        dir_t press;
        dir_t dir_q;
        logic press_ok;
        logic blocked;
        logic halt;

        ////////////////////////////////////////////////////////////
        // button presses
        ////////////////////////////////////////////////////////////

        // rising edges only
        assign press.right = right & ~buttons_q.right;
        assign press.left  = left  & ~buttons_q.left;
        assign press.up    = up    & ~buttons_q.up;
        assign press.down  = down  & ~buttons_q.down;

        // one direction, or a diagonal pair, but never opposite buttons
        assign press_ok = (press != '0)
                && !(press.right && press.left)
                && !(press.up && press.down);

        ////////////////////////////////////////////////////////////
        // sliding
        ////////////////////////////////////////////////////////////

        // idle engine asks about the pressed direction
        assign ahead_dir = moving ? dir_q : press;
        assign blocked   = ahead_cell == CELL_WALL;
        assign halt      = here_cell == CELL_STOP || here_cell == CELL_BOMB;

        always_ff @(posedge logicClock or posedge reset) begin
                if (reset) begin
                        buttons_q <= '0;
                        dir_q     <= '0;
                        moving    <= 1'b0;
                        cell_col  <= '0;
                        cell_row  <= '0;
                end else begin
                        buttons_q <= {right, left, up, down};
                        if (load) begin
                                cell_col <= start_col;
                                cell_row <= start_row;
                                dir_q    <= '0;
                                moving   <= 1'b0;
                        end else if (moving && (halt || blocked)) begin
                                // slide over, token stays put
                                dir_q  <= '0;
                                moving <= 1'b0;
                        end else if (moving || (!freeze && press_ok && !blocked)) begin
                                dir_q    <= ahead_dir;
                                moving   <= 1'b1;
                                cell_col <= cell_col + col_t'(ahead_dir.right)
                                        - col_t'(ahead_dir.left);
                                cell_row <= cell_row + row_t'(ahead_dir.down)
                                        - row_t'(ahead_dir.up);
                        end
                end
        end

endmodule

`default_nettype wire

/* board/board_store.sv */
`timescale 1ns/1ps
`default_nettype none

module board_store (
        input  logic                                   logicClock,
        input  logic                                   reset,
        input  logic                                   load,
        output puzzle_pkg::col_t  [puzzle_pkg::NUM_CELLS-1:0] load_col,
        output puzzle_pkg::row_t  [puzzle_pkg::NUM_CELLS-1:0] load_row,
        input  puzzle_pkg::cell_t [puzzle_pkg::NUM_CELLS-1:0] rom_cell,
        input  logic                                   collect,
        input  puzzle_pkg::col_t                       cell_col,
        input  puzzle_pkg::row_t                       cell_row,
        output puzzle_pkg::cell_t                      here_cell,
        input  puzzle_pkg::dir_t                       ahead_dir,
        output puzzle_pkg::cell_t                      ahead_cell,
        input  puzzle_pkg::col_t                       peek_col,
        input  puzzle_pkg::row_t                       peek_row,
        output puzzle_pkg::cell_t                      peek_cell
);
        import puzzle_pkg::*;

        cell_t      board [NUM_CELLS];
        // spare top bit catches a step off either edge
        logic [3:0] ahead_col;
        logic [4:0] ahead_row;

        function automatic int cell_idx(input col_t c, input row_t r);
                return int'(r) * BOARD_COLS + int'(c);
        endfunction

        // fixed scan address of every cell
        for (genvar i = 0; i < NUM_CELLS; i++) begin : g_scan
                assign load_col[i] = col_t'(i % BOARD_COLS);
                assign load_row[i] = row_t'(i / BOARD_COLS);
        end

        always_ff @(posedge logicClock or posedge reset) begin
                if (reset) begin
                        for (int i = 0; i < NUM_CELLS; i++) begin
                                board[i] <= CELL_EMPTY;
                        end
                end else if (load) begin
                        for (int i = 0; i < NUM_CELLS; i++) begin
                                board[i] <= rom_cell[i];
                        end
                end else if (collect) begin
                        board[cell_idx(cell_col, cell_row)] <= CELL_EMPTY;
                end
        end

        assign ahead_col = {1'b0, cell_col} + 4'(ahead_dir.right) - 4'(ahead_dir.left);
        assign ahead_row = {1'b0, cell_row} + 5'(ahead_dir.down) - 5'(ahead_dir.up);

        assign here_cell = board[cell_idx(cell_col, cell_row)];

        // off the board counts as a wall
        assign ahead_cell = (ahead_col >= BOARD_COLS || ahead_row >= BOARD_ROWS) ? CELL_WALL
                : board[cell_idx(ahead_col[2:0], ahead_row[3:0])];

        assign peek_cell = (peek_row < BOARD_ROWS) ? board[cell_idx(peek_col, peek_row)]
                : CELL_EMPTY;

endmodule

`default_nettype wire

/* board/level_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module level_rom (
        input  puzzle_pkg::level_t  level_sel,
        input  puzzle_pkg::col_t    rom_col,
        input  puzzle_pkg::row_t    rom_row,
        output puzzle_pkg::cell_t   rom_cell,
        output puzzle_pkg::col_t    start_col,
        output puzzle_pkg::row_t    start_row,
        output puzzle_pkg::gems_t   gem_total
);
        import puzzle_pkg::*;

        logic [6:0] addr;

        assign addr = {rom_col, rom_row};

        // only occupied cells are listed, the rest read empty
        always_comb begin
                rom_cell  = CELL_EMPTY;
                start_col = '0;
                start_row = '0;
                gem_total = '0;
                case (level_sel)
                        2'd0: begin
                                start_col = 3'd4;
                                start_row = 4'd2;
                                gem_total = 5'd2;
                                case (addr)
                                        {3'd0, 4'd4}: rom_cell = CELL_WALL;
                                        {3'd1, 4'd4}: rom_cell = CELL_GEM;
                                        {3'd1, 4'd7}: rom_cell = CELL_GEM;
                                        {3'd4, 4'd4}: rom_cell = CELL_STOP;
                                        {3'd4, 4'd5}: rom_cell = CELL_BOMB;
                                        default: rom_cell = CELL_EMPTY;
                                endcase
                        end
                        2'd1: begin
                                start_col = 3'd4;
                                start_row = 4'd8;
                                gem_total = 5'd3;
                                case (addr)
                                        {3'd0, 4'd2}: rom_cell = CELL_WALL;
                                        {3'd4, 4'd4}: rom_cell = CELL_WALL;
                                        {3'd5, 4'd4}: rom_cell = CELL_WALL;
                                        {3'd1, 4'd8}: rom_cell = CELL_WALL;
                                        {3'd1, 4'd4}: rom_cell = CELL_GEM;
                                        {3'd0, 4'd6}: rom_cell = CELL_GEM;
                                        {3'd5, 4'd7}: rom_cell = CELL_GEM;
                                        {3'd0, 4'd4}: rom_cell = CELL_BOMB;
                                        {3'd6, 4'd6}: rom_cell = CELL_BOMB;
                                        // (1,0) stopper makes the level solvable
                                        {3'd1, 4'd0}: rom_cell = CELL_STOP;
                                        {3'd2, 4'd4}: rom_cell = CELL_STOP;
                                        {3'd4, 4'd8}: rom_cell = CELL_STOP;
                                        {3'd6, 4'd8}: rom_cell = CELL_STOP;
                                        default: rom_cell = CELL_EMPTY;
                                endcase
                        end
                        default: begin
                                rom_cell = CELL_EMPTY;
                        end
                endcase
        end

endmodule

`default_nettype wire

/* common/puzzle_pkg.sv */
`default_nettype none

package puzzle_pkg;

        // board geometry
        localparam int BOARD_COLS = 8;
        localparam int BOARD_ROWS = 10;
        localparam int NUM_CELLS  = BOARD_COLS * BOARD_ROWS;

        typedef logic [2:0] col_t;
        typedef logic [3:0] row_t;
        typedef logic [1:0] level_t;
        typedef logic [4:0] gems_t;

        // cell codes as stored on the board
        typedef enum logic [2:0] {
                CELL_EMPTY = 3'd0,
                CELL_GEM   = 3'd1,
                CELL_WALL  = 3'd2,
                CELL_BOMB  = 3'd3,
                CELL_STOP  = 3'd4
        } cell_t;

        // slide direction, a horizontal and a vertical flag may be set together
        typedef struct packed {
                logic right;
                logic left;
                logic up;
                logic down;
        } dir_t;

endpackage

`default_nettype wire
